// ==== rtl/memPkg.sv ====
package memPkg;

    // core side
    localparam int addrWidth = 32;
    localparam int dataWidth = 32;

    // RAM side
    localparam int byteWidth = 8;

    // 1 KiB, core addresses wrap onto it
    localparam int ramAddrBits = 10;

    // an instruction fetch always reads a full word
    localparam int fetchBytes = 4;

    // data-port length, code 3 decodes as a word
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSize;

    // sequencer states
    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stFetch = 2'd1,
        stLoad  = 2'd2,
        stStore = 2'd3
    } seqState;

endpackage

// ==== rtl/apbPkg.sv ====
package apbPkg;

    localparam int apbAddrWidth = 8;
    localparam int apbDataWidth = 32;

    // register offsets
    localparam logic [apbAddrWidth-1:0] regCtrl       = 8'h00;
    localparam logic [apbAddrWidth-1:0] regStatus     = 8'h04;
    localparam logic [apbAddrWidth-1:0] regFetchCount = 8'h08;
    localparam logic [apbAddrWidth-1:0] regLoadCount  = 8'h0C;
    localparam logic [apbAddrWidth-1:0] regStoreCount = 8'h10;

    // control register bits
    localparam int ctrlHoldBit  = 0;
    localparam int ctrlClearBit = 1;

endpackage

// ==== rtl/byteRam.sv ====
`timescale 1ns/10ps

module byteRam (
    input  logic                           clk,
    input  logic [memPkg::ramAddrBits-1:0] addr,
    input  logic                           we,
    input  logic [memPkg::byteWidth-1:0]   wdata,
    output logic [memPkg::byteWidth-1:0]   rdata
);

    logic [memPkg::byteWidth-1:0] mem [0:(1 << memPkg::ramAddrBits)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// ==== rtl/memController.sv ====
`timescale 1ns/10ps

module memController (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 hold,

    input  logic                                 fetchEn,
    input  logic [memPkg::addrWidth-1:0]         fetchAddr,
    output logic                                 fetchDone,
    output logic [memPkg::dataWidth-1:0]         fetchInst,

    input  logic                                 dataEn,
    input  logic                                 dataStore,
    input  logic [$bits(memPkg::accessSize)-1:0] dataLen,
    input  logic [memPkg::addrWidth-1:0]         dataAddr,
    input  logic [memPkg::dataWidth-1:0]         dataWdata,
    output logic                                 dataDone,
    output logic [memPkg::dataWidth-1:0]         dataRdata,

    output logic [memPkg::ramAddrBits-1:0]       ramAddr,
    output logic                                 ramWe,
    output logic [memPkg::byteWidth-1:0]         ramWdata,
    input  logic [memPkg::byteWidth-1:0]         ramRdata,

    output logic                                 busy
);

    memPkg::seqState state;

    logic [2:0] idx;
    logic [2:0] nBytes;
    logic [2:0] dataBytes;
    logic [2:0] addrOffset;

    logic [memPkg::addrWidth-1:0] baseAddr;
    logic [memPkg::addrWidth-1:0] byteAddr;
    logic [memPkg::dataWidth-1:0] storeData;
    logic [memPkg::dataWidth-1:0] assembly;
    logic [memPkg::dataWidth-1:0] merged;

    logic readLast;
    logic storeLast;

    always_comb begin
        case (dataLen)
            memPkg::sizeByte: dataBytes = 3'd1;
            memPkg::sizeHalf: dataBytes = 3'd2;
            default:          dataBytes = 3'd4;
        endcase
    end

    // the byte arriving now belongs one slot below the index
    always_comb begin
        merged = assembly;
        if (idx != 3'd0) begin
            merged[(idx - 3'd1) * memPkg::byteWidth +: memPkg::byteWidth] = ramRdata;
        end
    end

    // while held, keep reading the previous byte so its data is still there on release
    always_comb begin
        addrOffset = idx;
        if (hold && idx != 3'd0) begin
            addrOffset = idx - 3'd1;
        end
        byteAddr = baseAddr + {{(memPkg::addrWidth - 3){1'b0}}, addrOffset};
    end

    assign ramAddr  = byteAddr[memPkg::ramAddrBits-1:0];
    assign ramWe    = (state == memPkg::stStore) && !hold;
    assign ramWdata = storeData[idx[1:0] * memPkg::byteWidth +: memPkg::byteWidth];

    // reads finish one step later than writes because of RAM latency
    assign readLast  = (idx == nBytes);
    assign storeLast = (idx == nBytes - 3'd1);

    assign fetchDone = !hold && (state == memPkg::stFetch) && readLast;
    assign dataDone  = !hold && (((state == memPkg::stLoad) && readLast) ||
                                 ((state == memPkg::stStore) && storeLast));

    // upper bytes stay zero from the clear at acceptance
    assign fetchInst = merged;
    assign dataRdata = merged;

    assign busy = (state != memPkg::stIdle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= memPkg::stIdle;
            idx    <= '0;
            nBytes <= '0;
        end else if (!hold) begin
            case (state)
                memPkg::stIdle: begin
                    idx <= '0;
                    // data port has priority
                    if (dataEn) begin
                        nBytes <= dataBytes;
                        state  <= dataStore ? memPkg::stStore : memPkg::stLoad;
                    end else if (fetchEn) begin
                        nBytes <= 3'(memPkg::fetchBytes);
                        state  <= memPkg::stFetch;
                    end
                end
                memPkg::stStore: begin
                    if (storeLast) begin
                        state <= memPkg::stIdle;
                    end else begin
                        idx <= idx + 3'd1;
                    end
                end
                default: begin
                    if (readLast) begin
                        state <= memPkg::stIdle;
                    end else begin
                        idx <= idx + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            if (state == memPkg::stIdle) begin
                assembly <= '0;
                if (dataEn) begin
                    baseAddr  <= dataAddr;
                    storeData <= dataWdata;
                end else begin
                    baseAddr <= fetchAddr;
                end
            end else begin
                assembly <= merged;
            end
        end
    end

endmodule

// ==== rtl/memCtrlRegs.sv ====
`timescale 1ns/10ps

module memCtrlRegs (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [apbPkg::apbAddrWidth-1:0] paddr,
    input  logic [apbPkg::apbDataWidth-1:0] pwdata,
    output logic [apbPkg::apbDataWidth-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,

    input  logic                            busy,
    input  logic                            fetchDone,
    input  logic                            dataDone,
    input  logic                            dataStore,
    output logic                            hold
);

    logic access;
    logic mapped;
    logic ctrlWrite;
    logic clear;
    logic holdReg;

    logic [apbPkg::apbDataWidth-1:0] readData;
    logic [apbPkg::apbDataWidth-1:0] fetchCount;
    logic [apbPkg::apbDataWidth-1:0] loadCount;
    logic [apbPkg::apbDataWidth-1:0] storeCount;

    assign access    = psel && penable;
    assign ctrlWrite = access && pwrite && (paddr == apbPkg::regCtrl);
    // clear is a pulse only, it is never stored
    assign clear     = ctrlWrite && pwdata[apbPkg::ctrlClearBit];

    always_comb begin
        mapped   = 1'b1;
        readData = '0;
        case (paddr)
            apbPkg::regCtrl:       readData[apbPkg::ctrlHoldBit] = holdReg;
            apbPkg::regStatus:     readData[0] = busy;
            apbPkg::regFetchCount: readData = fetchCount;
            apbPkg::regLoadCount:  readData = loadCount;
            apbPkg::regStoreCount: readData = storeCount;
            default:               mapped = 1'b0;
        endcase
    end

    assign prdata  = readData;
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;
    assign hold    = holdReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            holdReg <= 1'b0;
        end else if (ctrlWrite) begin
            holdReg <= pwdata[apbPkg::ctrlHoldBit];
        end
    end

    // completion counters, wrap silently
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchCount <= '0;
            loadCount  <= '0;
            storeCount <= '0;
        end else if (clear) begin
            fetchCount <= '0;
            loadCount  <= '0;
            storeCount <= '0;
        end else begin
            if (fetchDone) begin
                fetchCount <= fetchCount + 1'b1;
            end
            if (dataDone && !dataStore) begin
                loadCount <= loadCount + 1'b1;
            end
            if (dataDone && dataStore) begin
                storeCount <= storeCount + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/memSubsystem.sv ====
`timescale 1ns/10ps

module memSubsystem (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic                                 fetchEn,
    input  logic [memPkg::addrWidth-1:0]         fetchAddr,
    output logic                                 fetchDone,
    output logic [memPkg::dataWidth-1:0]         fetchInst,

    input  logic                                 dataEn,
    input  logic                                 dataStore,
    input  logic [$bits(memPkg::accessSize)-1:0] dataLen,
    input  logic [memPkg::addrWidth-1:0]         dataAddr,
    input  logic [memPkg::dataWidth-1:0]         dataWdata,
    output logic                                 dataDone,
    output logic [memPkg::dataWidth-1:0]         dataRdata,

    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [apbPkg::apbAddrWidth-1:0]      paddr,
    input  logic [apbPkg::apbDataWidth-1:0]      pwdata,
    output logic [apbPkg::apbDataWidth-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    logic hold;
    logic busy;

    logic [memPkg::ramAddrBits-1:0] ramAddr;
    logic                           ramWe;
    logic [memPkg::byteWidth-1:0]   ramWdata;
    logic [memPkg::byteWidth-1:0]   ramRdata;

    memCtrlRegs ctrlRegs (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .busy(busy),
        .fetchDone(fetchDone),
        .dataDone(dataDone),
        .dataStore(dataStore),
        .hold(hold)
    );

    memController sequencer (
        .clk(clk),
        .rst(rst),
        .hold(hold),
        .fetchEn(fetchEn),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .dataEn(dataEn),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata),
        .ramAddr(ramAddr),
        .ramWe(ramWe),
        .ramWdata(ramWdata),
        .ramRdata(ramRdata),
        .busy(busy)
    );

    byteRam ram (
        .clk(clk),
        .addr(ramAddr),
        .we(ramWe),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

endmodule

// ==== test/memSubsystemTasks.svh ====
task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

function automatic int byteCount(input memPkg::accessSize len);
    case (len)
        memPkg::sizeByte: return 1;
        memPkg::sizeHalf: return 2;
        default:          return 4;
    endcase
endfunction

task automatic apbWrite(input logic [apbPkg::apbAddrWidth-1:0] addr,
                        input logic [apbPkg::apbDataWidth-1:0] data, input logic expErr);
    @(posedge clk);
    #2;
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    checkValue("pready on write", pready, 1'b1);
    checkValue("pslverr on write", pslverr, expErr);
    // write lands on this edge
    @(posedge clk);
    #2;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

task automatic apbRead(input logic [apbPkg::apbAddrWidth-1:0] addr,
                       input logic [apbPkg::apbDataWidth-1:0] exp, input logic expErr,
                       input string what);
    @(posedge clk);
    #2;
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    #1;
    checkValue(what, prdata, exp);
    checkValue("pslverr on read", pslverr, expErr);
    @(posedge clk);
    #2;
    psel = 1'b0;
    penable = 1'b0;
endtask

// samples 1 ns after each edge and counts edges since the enable went up
task automatic awaitDone(input bit isFetch, output int cycles, output logic [31:0] value);
    bit seen;
    seen = 1'b0;
    cycles = 0;
    value = '0;
    while (!seen && cycles < doneLimit) begin
        @(posedge clk);
        #1;
        cycles++;
        seen = isFetch ? fetchDone : dataDone;
        value = isFetch ? fetchInst : dataRdata;
    end
    if (!seen) begin
        errors++;
        $display("timeout: %s done never arrived within %0d cycles",
                 isFetch ? "fetch" : "data", cycles);
    end
endtask

// ==== test/memSubsystemTb.sv ====
`timescale 1ns/10ps

module memSubsystemTb;

    localparam int clkPeriod = 20;
    localparam int numRows = 12;
    localparam int doneLimit = 40;
    localparam int directedCycles = 150;
    localparam int watchdogCycles = numRows * 20 + directedCycles + 200;

    typedef enum int {opStore, opLoad, opFetch} reqOp;

    logic clk;
    logic rst;
    logic fetchEn;
    logic [31:0] fetchAddr;
    logic fetchDone;
    logic [31:0] fetchInst;
    logic dataEn;
    logic dataStore;
    logic [1:0] dataLen;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic dataDone;
    logic [31:0] dataRdata;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    int errors = 0;
    int checks = 0;
    int seed = 32'h3d73;

    logic [31:0] addrA;
    logic [31:0] addrB;

    // reference byte image of the RAM
    logic [7:0] model [0:(1 << memPkg::ramAddrBits)-1];

    reqOp rowOp [numRows];
    logic [31:0] rowAddr [numRows];
    memPkg::accessSize rowLen [numRows];
    logic [31:0] rowData [numRows];
    logic [31:0] rowExp [numRows];

    `include "memSubsystemTasks.svh"

    memSubsystem i_dut (
        .clk(clk),
        .rst(rst),
        .fetchEn(fetchEn),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .dataEn(dataEn),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    // little endian, upper bytes stay zero
    function automatic logic [31:0] modelRead(input logic [31:0] addr, input int n);
        logic [31:0] value;
        logic [31:0] a;
        value = '0;
        for (int k = 0; k < n; k++) begin
            a = addr + k;
            value[k*8 +: 8] = model[a[memPkg::ramAddrBits-1:0]];
        end
        return value;
    endfunction

    function automatic void modelWrite(input logic [31:0] addr, input int n,
                                       input logic [31:0] data);
        logic [31:0] a;
        for (int k = 0; k < n; k++) begin
            a = addr + k;
            model[a[memPkg::ramAddrBits-1:0]] = data[k*8 +: 8];
        end
    endfunction

    task automatic setRow(input int i, input reqOp op, input logic [31:0] addr,
                          input memPkg::accessSize len, input logic [31:0] data);
        rowOp[i] = op;
        rowAddr[i] = addr;
        rowLen[i] = len;
        rowData[i] = data;
    endtask

    task automatic buildTable();
        int n;
        addrA = $random(seed) & 32'h0000_01fc;
        addrB = 32'h0000_0200 | ($random(seed) & 32'h0000_01fc);
        setRow(0, opStore, addrA, memPkg::sizeWord, $random(seed));
        setRow(1, opLoad, addrA, memPkg::sizeWord, 32'h0);
        setRow(2, opLoad, addrA + 2, memPkg::sizeHalf, 32'h0);
        setRow(3, opLoad, addrA + 1, memPkg::sizeByte, 32'h0);
        setRow(4, opStore, addrA + 1, memPkg::sizeHalf, $random(seed));
        setRow(5, opLoad, addrA, memPkg::sizeWord, 32'h0);
        setRow(6, opFetch, addrA, memPkg::sizeWord, 32'h0);
        setRow(7, opStore, addrB, memPkg::sizeByte, $random(seed));
        setRow(8, opStore, addrB + 1, memPkg::sizeByte, $random(seed));
        // these three sit above 1023 and wrap back onto addrB
        setRow(9, opStore, addrB + 32'h1000_0002, memPkg::sizeHalf, $random(seed));
        setRow(10, opLoad, addrB + 32'h8000_0400, memPkg::sizeWord, 32'h0);
        setRow(11, opFetch, addrB + 32'h0000_0400, memPkg::sizeWord, 32'h0);
        for (int i = 0; i < numRows; i++) begin
            n = (rowOp[i] == opFetch) ? memPkg::fetchBytes : byteCount(rowLen[i]);
            rowExp[i] = '0;
            if (rowOp[i] == opStore) begin
                modelWrite(rowAddr[i], n, rowData[i]);
            end else begin
                rowExp[i] = modelRead(rowAddr[i], n);
            end
        end
    endtask

    task automatic runRequest(input reqOp op, input logic [31:0] addr,
                              input memPkg::accessSize len, input logic [31:0] wdata,
                              input logic [31:0] exp);
        int cycles;
        int n;
        logic [31:0] value;
        n = (op == opFetch) ? memPkg::fetchBytes : byteCount(len);
        @(posedge clk);
        #2;
        if (op == opFetch) begin
            fetchEn = 1'b1;
            fetchAddr = addr;
        end else begin
            dataEn = 1'b1;
            dataStore = (op == opStore);
            dataLen = len;
            dataAddr = addr;
            dataWdata = wdata;
        end
        awaitDone(op == opFetch, cycles, value);
        #1;
        fetchEn = 1'b0;
        dataEn = 1'b0;
        if (op != opStore) begin
            checkValue("read data", value, exp);
        end
        // reads pay one extra cycle of RAM latency
        checkValue("latency", cycles, (op == opStore) ? n : n + 1);
    endtask

    task automatic counterReadback();
        int nFetch;
        int nLoad;
        int nStore;
        nFetch = 0;
        nLoad = 0;
        nStore = 0;
        for (int i = 0; i < numRows; i++) begin
            case (rowOp[i])
                opFetch: nFetch++;
                opLoad:  nLoad++;
                default: nStore++;
            endcase
        end
        apbRead(apbPkg::regFetchCount, nFetch, 1'b0, "fetch count");
        apbRead(apbPkg::regLoadCount, nLoad, 1'b0, "load count");
        apbRead(apbPkg::regStoreCount, nStore, 1'b0, "store count");
    endtask

    task automatic dataPriority();
        int cycles;
        logic [31:0] value;
        @(posedge clk);
        #2;
        fetchEn = 1'b1;
        fetchAddr = addrA;
        dataEn = 1'b1;
        dataStore = 1'b0;
        dataLen = memPkg::sizeWord;
        dataAddr = addrB;
        awaitDone(1'b0, cycles, value);
        #1;
        dataEn = 1'b0;
        checkValue("load beside fetch", value, modelRead(addrB, 4));
        checkValue("load served first", cycles, byteCount(memPkg::sizeWord) + 1);
        // fetchEn stays up the whole time
        awaitDone(1'b1, cycles, value);
        #1;
        fetchEn = 1'b0;
        checkValue("fetch after load", value, modelRead(addrA, memPkg::fetchBytes));
    endtask

    task automatic holdMidFetch();
        int cycles;
        logic [31:0] value;
        @(posedge clk);
        #2;
        fetchEn = 1'b1;
        fetchAddr = addrA;
        // hold lands two bytes into the fetch
        apbWrite(apbPkg::regCtrl, 32'(1) << apbPkg::ctrlHoldBit, 1'b0);
        repeat (6) begin
            @(posedge clk);
            #1;
            checkValue("fetchDone while held", fetchDone, 1'b0);
        end
        apbRead(apbPkg::regStatus, 32'h1, 1'b0, "busy while held");
        apbWrite(apbPkg::regCtrl, 32'h0, 1'b0);
        awaitDone(1'b1, cycles, value);
        #1;
        fetchEn = 1'b0;
        checkValue("fetch after hold", value, modelRead(addrA, memPkg::fetchBytes));
    endtask

    task automatic clearAndCtrl();
        apbWrite(apbPkg::regCtrl,
                 (32'(1) << apbPkg::ctrlClearBit) | (32'(1) << apbPkg::ctrlHoldBit), 1'b0);
        apbRead(apbPkg::regFetchCount, 32'h0, 1'b0, "fetch count after clear");
        apbRead(apbPkg::regLoadCount, 32'h0, 1'b0, "load count after clear");
        apbRead(apbPkg::regStoreCount, 32'h0, 1'b0, "store count after clear");
        apbRead(apbPkg::regCtrl, 32'(1) << apbPkg::ctrlHoldBit, 1'b0, "ctrl readback");
        apbWrite(apbPkg::regCtrl, 32'h0, 1'b0);
        apbRead(apbPkg::regStatus, 32'h0, 1'b0, "status when idle");
    endtask

    task automatic unmappedAccess();
        apbWrite(8'h14, 32'hffff_ffff, 1'b1);
        apbRead(8'h14, 32'h0, 1'b1, "unmapped read");
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("timeout: run still going after %0d cycles", watchdogCycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = '0;
        dataAddr = '0;
        dataWdata = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        buildTable();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < numRows; i++) begin
            runRequest(rowOp[i], rowAddr[i], rowLen[i], rowData[i], rowExp[i]);
        end
        counterReadback();
        dataPriority();
        holdMidFetch();
        clearAndCtrl();
        unmappedAccess();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+test
rtl/memPkg.sv
rtl/apbPkg.sv
rtl/byteRam.sv
rtl/memController.sv
rtl/memCtrlRegs.sv
rtl/memSubsystem.sv
test/memSubsystemTb.sv
